// File: branch_core_pkg.sv
`default_nettype none

package branch_core_pkg;

    localparam int XLEN       = 32;   // data and pc width
    localparam int PTAG_W     = 6;    // physical register tag
    localparam int PREG_COUNT = 64;
    localparam int INUM_W     = 32;   // sequence number from dispatch
    localparam int RS_DEPTH   = 16;
    localparam int RS_PTR_W   = 5;    // index plus wrap bit

endpackage

`default_nettype wire

// File: branch_isa_pkg.sv
`default_nettype none

package branch_isa_pkg;

    // major opcodes handled by the branch unit
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // conditional branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;     // sits in the rd slot
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one instruction word, three decodings
    typedef union packed {
        b_type_t b_view;
        j_type_t j_view;
        i_type_t i_view;
    } inst_word_u;

endpackage

`default_nettype wire

// File: branch_operand_read.sv
`timescale 1ns/100ps
`default_nettype none

module branch_operand_read (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               flush,
    input  logic                               iss_valid,
    input  logic [branch_core_pkg::INUM_W-1:0] iss_inum,
    input  logic [branch_core_pkg::XLEN-1:0]   iss_pc,
    input  branch_isa_pkg::inst_word_u         iss_inst,
    input  logic [branch_core_pkg::PTAG_W-1:0] iss_rd_tag,
    input  logic [branch_core_pkg::PTAG_W-1:0] iss_src1_tag,
    input  logic [branch_core_pkg::PTAG_W-1:0] iss_src2_tag,
    input  logic                               iss_pred_taken,
    input  logic [branch_core_pkg::XLEN-1:0]   iss_pred_target,
    input  logic                               wb0_valid,
    input  logic [branch_core_pkg::PTAG_W-1:0] wb0_tag,
    input  logic [branch_core_pkg::XLEN-1:0]   wb0_data,
    input  logic                               wb1_valid,
    input  logic [branch_core_pkg::PTAG_W-1:0] wb1_tag,
    input  logic [branch_core_pkg::XLEN-1:0]   wb1_data,
    output logic                               rd_valid,
    output logic [branch_core_pkg::INUM_W-1:0] rd_inum,
    output logic [branch_core_pkg::XLEN-1:0]   rd_pc,
    output branch_isa_pkg::inst_word_u         rd_inst,
    output logic [branch_core_pkg::PTAG_W-1:0] rd_rd_tag,
    output logic                               rd_pred_taken,
    output logic [branch_core_pkg::XLEN-1:0]   rd_pred_target,
    output logic [branch_core_pkg::XLEN-1:0]   rd_src1_data,
    output logic [branch_core_pkg::XLEN-1:0]   rd_src2_data
);

    logic [branch_core_pkg::XLEN-1:0] src1_val;
    logic [branch_core_pkg::XLEN-1:0] src2_val;

    branch_prf branch_prf_i (
        .clk      (clk),
        .reset    (reset),
        .wb0_valid(wb0_valid),
        .wb0_tag  (wb0_tag),
        .wb0_data (wb0_data),
        .wb1_valid(wb1_valid),
        .wb1_tag  (wb1_tag),
        .wb1_data (wb1_data),
        .rd1_tag  (iss_src1_tag),
        .rd2_tag  (iss_src2_tag),
        .rd1_data (src1_val),
        .rd2_data (src2_val)
    );

    always_ff @(posedge clk) begin
        if (reset) rd_valid <= 1'b0;
        else rd_valid <= iss_valid && !flush;   // younger than the mispredict
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            rd_inum        <= iss_inum;
            rd_pc          <= iss_pc;
            rd_inst        <= iss_inst;
            rd_rd_tag      <= iss_rd_tag;
            rd_pred_taken  <= iss_pred_taken;
            rd_pred_target <= iss_pred_target;
            rd_src1_data   <= src1_val;   // written at the wakeup edge
            rd_src2_data   <= src2_val;
        end
    end

endmodule

`default_nettype wire

// File: branch_prf.sv
`timescale 1ns/100ps
`default_nettype none

module branch_prf (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wb0_valid,
    input  logic [branch_core_pkg::PTAG_W-1:0] wb0_tag,
    input  logic [branch_core_pkg::XLEN-1:0]   wb0_data,
    input  logic                               wb1_valid,
    input  logic [branch_core_pkg::PTAG_W-1:0] wb1_tag,
    input  logic [branch_core_pkg::XLEN-1:0]   wb1_data,
    input  logic [branch_core_pkg::PTAG_W-1:0] rd1_tag,
    input  logic [branch_core_pkg::PTAG_W-1:0] rd2_tag,
    output logic [branch_core_pkg::XLEN-1:0]   rd1_data,
    output logic [branch_core_pkg::XLEN-1:0]   rd2_data
);

    logic [branch_core_pkg::XLEN-1:0] regs [branch_core_pkg::PREG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < branch_core_pkg::PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0_valid) regs[wb0_tag] <= wb0_data;
            if (wb1_valid) regs[wb1_tag] <= wb1_data;   // load bus wins a tie
        end
    end

    assign rd1_data = regs[rd1_tag];
    assign rd2_data = regs[rd2_tag];

endmodule

`default_nettype wire

// File: branch_resolve.sv
`timescale 1ns/100ps
`default_nettype none

module branch_resolve (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rd_valid,
    input  logic [branch_core_pkg::INUM_W-1:0] rd_inum,
    input  logic [branch_core_pkg::XLEN-1:0]   rd_pc,
    input  branch_isa_pkg::inst_word_u         rd_inst,
    input  logic [branch_core_pkg::PTAG_W-1:0] rd_rd_tag,
    input  logic                               rd_pred_taken,
    input  logic [branch_core_pkg::XLEN-1:0]   rd_pred_target,
    input  logic [branch_core_pkg::XLEN-1:0]   rd_src1_data,
    input  logic [branch_core_pkg::XLEN-1:0]   rd_src2_data,
    output logic                               resolve_valid,
    output logic [branch_core_pkg::INUM_W-1:0] resolve_inum,
    output logic                               resolve_taken,
    output logic                               mispredict,
    output logic [branch_core_pkg::XLEN-1:0]   redirect_pc,
    output logic                               link_valid,
    output logic [branch_core_pkg::PTAG_W-1:0] link_tag,
    output logic [branch_core_pkg::XLEN-1:0]   link_data
);

    logic [branch_core_pkg::XLEN-1:0] b_imm;
    logic [branch_core_pkg::XLEN-1:0] j_imm;
    logic [branch_core_pkg::XLEN-1:0] i_imm;
    logic [branch_core_pkg::XLEN-1:0] target;
    logic [branch_core_pkg::XLEN-1:0] pc_plus4;
    logic                             cond;
    logic                             taken;
    logic                             is_jump;
    logic                             miss;
    logic                             live;

    // immediates from the scattered fields
    assign b_imm = {{19{rd_inst.b_view.imm12}}, rd_inst.b_view.imm12, rd_inst.b_view.imm11,
                    rd_inst.b_view.imm10_5, rd_inst.b_view.imm4_1, 1'b0};
    assign j_imm = {{11{rd_inst.j_view.imm20}}, rd_inst.j_view.imm20, rd_inst.j_view.imm19_12,
                    rd_inst.j_view.imm11, rd_inst.j_view.imm10_1, 1'b0};
    assign i_imm = {{20{rd_inst.i_view.imm[11]}}, rd_inst.i_view.imm};
    assign pc_plus4 = rd_pc + 32'd4;

    always_comb begin
        case (rd_inst.b_view.funct3)
            branch_isa_pkg::F3_BEQ:  cond = (rd_src1_data == rd_src2_data);
            branch_isa_pkg::F3_BNE:  cond = (rd_src1_data != rd_src2_data);
            branch_isa_pkg::F3_BLT:  cond = ($signed(rd_src1_data) < $signed(rd_src2_data));
            branch_isa_pkg::F3_BGE:  cond = ($signed(rd_src1_data) >= $signed(rd_src2_data));
            branch_isa_pkg::F3_BLTU: cond = (rd_src1_data < rd_src2_data);
            branch_isa_pkg::F3_BGEU: cond = (rd_src1_data >= rd_src2_data);
            default:                 cond = 1'b0;
        endcase
    end

    always_comb begin
        taken   = 1'b0;
        is_jump = 1'b0;
        target  = rd_pc + b_imm;
        case (rd_inst.i_view.opcode)
            branch_isa_pkg::OP_BRANCH: taken = cond;
            branch_isa_pkg::OP_JAL: begin
                taken   = 1'b1;
                is_jump = 1'b1;
                target  = rd_pc + j_imm;
            end
            branch_isa_pkg::OP_JALR: begin
                taken     = 1'b1;
                is_jump   = 1'b1;
                target    = rd_src1_data + i_imm;
                target[0] = 1'b0;
            end
            default: ;
        endcase
    end

    assign miss = (taken != rd_pred_taken) || (taken && rd_pred_taken && target != rd_pred_target);
    // the stage behind a mispredict holds a younger branch
    assign live = rd_valid && !mispredict;

    always_ff @(posedge clk) begin
        if (reset) begin
            resolve_valid <= 1'b0;
            mispredict    <= 1'b0;
            link_valid    <= 1'b0;
        end else begin
            resolve_valid <= live;
            mispredict    <= live && miss;
            link_valid    <= live && is_jump;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            resolve_inum  <= rd_inum;
            resolve_taken <= taken;
            redirect_pc   <= taken ? target : pc_plus4;
            link_tag      <= rd_rd_tag;
            link_data     <= pc_plus4;   // return address
        end
    end

endmodule

`default_nettype wire

// File: branch_rs.sv
`timescale 1ns/100ps
`default_nettype none

module branch_rs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 flush,
    input  logic                                 dispatch_valid,
    input  logic [branch_core_pkg::INUM_W-1:0]   dispatch_inum,
    input  logic [branch_core_pkg::XLEN-1:0]     dispatch_pc,
    input  branch_isa_pkg::inst_word_u           dispatch_inst,
    input  logic [branch_core_pkg::PTAG_W-1:0]   dispatch_rd_tag,
    input  logic [branch_core_pkg::PTAG_W-1:0]   dispatch_src1_tag,
    input  logic [branch_core_pkg::PTAG_W-1:0]   dispatch_src2_tag,
    input  logic                                 dispatch_src1_ready,
    input  logic                                 dispatch_src2_ready,
    input  logic                                 dispatch_pred_taken,
    input  logic [branch_core_pkg::XLEN-1:0]     dispatch_pred_target,
    input  logic                                 wb0_valid,
    input  logic [branch_core_pkg::PTAG_W-1:0]   wb0_tag,
    input  logic                                 wb1_valid,
    input  logic [branch_core_pkg::PTAG_W-1:0]   wb1_tag,
    output logic                                 rs_full,
    output logic                                 iss_valid,
    output logic [branch_core_pkg::INUM_W-1:0]   iss_inum,
    output logic [branch_core_pkg::XLEN-1:0]     iss_pc,
    output branch_isa_pkg::inst_word_u           iss_inst,
    output logic [branch_core_pkg::PTAG_W-1:0]   iss_rd_tag,
    output logic [branch_core_pkg::PTAG_W-1:0]   iss_src1_tag,
    output logic [branch_core_pkg::PTAG_W-1:0]   iss_src2_tag,
    output logic                                 iss_pred_taken,
    output logic [branch_core_pkg::XLEN-1:0]     iss_pred_target
);

    localparam int DEPTH = branch_core_pkg::RS_DEPTH;
    localparam int IDX_W = branch_core_pkg::RS_PTR_W - 1;

    logic [branch_core_pkg::INUM_W-1:0] inum_q        [DEPTH];
    logic [branch_core_pkg::XLEN-1:0]   pc_q          [DEPTH];
    branch_isa_pkg::inst_word_u         inst_q        [DEPTH];
    logic [branch_core_pkg::PTAG_W-1:0] rd_tag_q      [DEPTH];
    logic [branch_core_pkg::PTAG_W-1:0] src1_tag_q    [DEPTH];
    logic [branch_core_pkg::PTAG_W-1:0] src2_tag_q    [DEPTH];
    logic [branch_core_pkg::XLEN-1:0]   pred_target_q [DEPTH];
    logic [DEPTH-1:0]                   pred_taken_q;
    logic [DEPTH-1:0]                   rdy1;
    logic [DEPTH-1:0]                   rdy2;

    logic [branch_core_pkg::RS_PTR_W-1:0] head;
    logic [branch_core_pkg::RS_PTR_W-1:0] tail;
    logic [IDX_W-1:0]                     head_idx;
    logic [IDX_W-1:0]                     tail_idx;
    logic                                 empty;
    logic                                 push;
    logic                                 head_ready;

    // tag hit on either result bus
    function automatic logic woken(input logic [branch_core_pkg::PTAG_W-1:0] tag);
        return (wb0_valid && wb0_tag == tag) || (wb1_valid && wb1_tag == tag);
    endfunction

    assign head_idx   = head[IDX_W-1:0];
    assign tail_idx   = tail[IDX_W-1:0];
    assign empty      = (head == tail);
    assign rs_full    = (head[IDX_W] != tail[IDX_W]) && (head_idx == tail_idx);
    assign push       = dispatch_valid && !rs_full && !flush;   // dropped when full
    assign head_ready = !empty && rdy1[head_idx] && rdy2[head_idx];

    always_ff @(posedge clk) begin
        if (push) begin
            inum_q[tail_idx]        <= dispatch_inum;
            pc_q[tail_idx]          <= dispatch_pc;
            inst_q[tail_idx]        <= dispatch_inst;
            rd_tag_q[tail_idx]      <= dispatch_rd_tag;
            src1_tag_q[tail_idx]    <= dispatch_src1_tag;
            src2_tag_q[tail_idx]    <= dispatch_src2_tag;
            pred_taken_q[tail_idx]  <= dispatch_pred_taken;
            pred_target_q[tail_idx] <= dispatch_pred_target;
        end
        if (head_ready) begin
            iss_inum        <= inum_q[head_idx];
            iss_pc          <= pc_q[head_idx];
            iss_inst        <= inst_q[head_idx];
            iss_rd_tag      <= rd_tag_q[head_idx];
            iss_src1_tag    <= src1_tag_q[head_idx];
            iss_src2_tag    <= src2_tag_q[head_idx];
            iss_pred_taken  <= pred_taken_q[head_idx];
            iss_pred_target <= pred_target_q[head_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head      <= '0;
            tail      <= '0;
            rdy1      <= '0;
            rdy2      <= '0;
            iss_valid <= 1'b0;
        end else begin
            // wakeup of waiting sources
            for (int i = 0; i < DEPTH; i++) begin
                if (woken(src1_tag_q[i])) rdy1[i] <= 1'b1;
                if (woken(src2_tag_q[i])) rdy2[i] <= 1'b1;
            end
            if (push) begin
                // a broadcast in the dispatch cycle counts too
                rdy1[tail_idx] <= dispatch_src1_ready || woken(dispatch_src1_tag);
                rdy2[tail_idx] <= dispatch_src2_ready || woken(dispatch_src2_tag);
                tail <= tail + 1'b1;
            end
            if (head_ready) head <= head + 1'b1;   // strictly in order
            iss_valid <= head_ready;
        end
    end

endmodule

`default_nettype wire

// File: branch_unit.f
branch_core_pkg.sv
branch_isa_pkg.sv
branch_rs.sv
branch_prf.sv
branch_operand_read.sv
branch_resolve.sv
branch_unit_top.sv
branch_unit_tb.sv

// File: branch_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit_tb;

    localparam int N_DISPATCH = 200;
    localparam int STALL_TAG  = 63;   // only used by dispatches inside a fill window

    typedef struct packed {
        logic [branch_core_pkg::INUM_W-1:0] inum;
        logic [branch_core_pkg::XLEN-1:0]   pc;
        branch_isa_pkg::inst_word_u         inst;
        logic [branch_core_pkg::PTAG_W-1:0] rd_tag;
        logic [branch_core_pkg::PTAG_W-1:0] s1;
        logic [branch_core_pkg::PTAG_W-1:0] s2;
        logic                               pred_taken;
        logic [branch_core_pkg::XLEN-1:0]   pred_target;
    } entry_t;

    logic                               clk;
    logic                               reset;
    logic                               dispatch_valid;
    logic [branch_core_pkg::INUM_W-1:0] dispatch_inum;
    logic [branch_core_pkg::XLEN-1:0]   dispatch_pc;
    branch_isa_pkg::inst_word_u         dispatch_inst;
    logic [branch_core_pkg::PTAG_W-1:0] dispatch_rd_tag;
    logic [branch_core_pkg::PTAG_W-1:0] dispatch_src1_tag;
    logic [branch_core_pkg::PTAG_W-1:0] dispatch_src2_tag;
    logic                               dispatch_src1_ready;
    logic                               dispatch_src2_ready;
    logic                               dispatch_pred_taken;
    logic [branch_core_pkg::XLEN-1:0]   dispatch_pred_target;
    logic                               wb0_valid;
    logic [branch_core_pkg::PTAG_W-1:0] wb0_tag;
    logic [branch_core_pkg::XLEN-1:0]   wb0_data;
    logic                               wb1_valid;
    logic [branch_core_pkg::PTAG_W-1:0] wb1_tag;
    logic [branch_core_pkg::XLEN-1:0]   wb1_data;
    logic                               rs_full;
    logic                               resolve_valid;
    logic [branch_core_pkg::INUM_W-1:0] resolve_inum;
    logic                               resolve_taken;
    logic                               mispredict;
    logic [branch_core_pkg::XLEN-1:0]   redirect_pc;
    logic                               link_valid;
    logic [branch_core_pkg::PTAG_W-1:0] link_tag;
    logic [branch_core_pkg::XLEN-1:0]   link_data;

    // reference model state
    entry_t                           q[$];   // unresolved branches, oldest first
    logic [branch_core_pkg::XLEN-1:0] regs [branch_core_pkg::PREG_COUNT];
    logic [branch_core_pkg::PREG_COUNT-1:0] pend;   // tags whose producer has not broadcast
    integer seed = 27992;
    int     cycle;
    int     dcount;
    int     mismatches;
    int     failures;
    bit     full_seen;
    bit     draining;

    branch_unit_top branch_unit_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(N_DISPATCH * 40 * 100);
        $display("timeout: the run did not finish within %0d cycles, the DUT hangs",
                 N_DISPATCH * 40);
        $display("Regression failed");
        $finish;
    end

    function automatic int unsigned urand(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic bit referenced(input logic [branch_core_pkg::PTAG_W-1:0] tag);
        foreach (q[i]) begin
            if (q[i].s1 == tag || q[i].s2 == tag) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic bit pick_pending(output logic [branch_core_pkg::PTAG_W-1:0] tag);
        int start;
        start = urand(branch_core_pkg::PREG_COUNT);
        for (int i = 0; i < branch_core_pkg::PREG_COUNT; i++) begin
            tag = (start + i) % branch_core_pkg::PREG_COUNT;
            if (pend[tag]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // immediates taken from raw bit positions of the ISA encoding
    function automatic logic [31:0] target_of(input entry_t e);
        logic [31:0] w;
        w = e.inst;
        case (w[6:0])
            branch_isa_pkg::OP_JAL:
                return e.pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            branch_isa_pkg::OP_JALR:
                return (regs[e.s1] + {{20{w[31]}}, w[31:20]}) & ~32'h1;
            default:
                return e.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        endcase
    endfunction

    function automatic logic taken_of(input entry_t e);
        logic [31:0] a;
        logic [31:0] b;
        a = regs[e.s1];
        b = regs[e.s2];
        if (e.inst[6:0] != branch_isa_pkg::OP_BRANCH) return 1'b1;   // jumps always taken
        case (e.inst[14:12])
            branch_isa_pkg::F3_BEQ:  return a == b;
            branch_isa_pkg::F3_BNE:  return a != b;
            branch_isa_pkg::F3_BLT:  return $signed(a) < $signed(b);
            branch_isa_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            branch_isa_pkg::F3_BLTU: return a < b;
            branch_isa_pkg::F3_BGEU: return a >= b;
            default:                 return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch %s: expected 0x%h, actual 0x%h", what, exp, act);
        mismatches++;
    endtask

    task automatic check_resolve(input string name,
                                 input logic [branch_core_pkg::INUM_W-1:0] exp_inum,
                                 input logic exp_taken,
                                 input logic [branch_core_pkg::XLEN-1:0] exp_redirect,
                                 input logic exp_mispredict);
        if (resolve_inum !== exp_inum) report_mismatch({name, " inum"}, exp_inum, resolve_inum);
        if (resolve_taken !== exp_taken) report_mismatch({name, " taken"}, exp_taken, resolve_taken);
        if (redirect_pc !== exp_redirect)
            report_mismatch({name, " redirect_pc"}, exp_redirect, redirect_pc);
        if (mispredict !== exp_mispredict)
            report_mismatch({name, " mispredict"}, exp_mispredict, mispredict);
    endtask

    task automatic check_link(input string name,
                              input logic [branch_core_pkg::PTAG_W-1:0] exp_tag,
                              input logic [branch_core_pkg::XLEN-1:0] exp_data);
        if (link_tag !== exp_tag) report_mismatch({name, " link_tag"}, exp_tag, link_tag);
        if (link_data !== exp_data) report_mismatch({name, " link_data"}, exp_data, link_data);
    endtask

    task automatic drive_stimulus();
        entry_t                             e;
        logic [branch_core_pkg::PTAG_W-1:0] t;
        logic [branch_core_pkg::XLEN-1:0]   d;
        int unsigned                        sel;
        bit                                 stall;
        stall = !draining && (cycle % 120 >= 80);   // no broadcasts so the station fills up
        dispatch_valid <= 1'b0;
        wb0_valid      <= 1'b0;
        wb1_valid      <= 1'b0;
        if (stall && !referenced(STALL_TAG)) pend[STALL_TAG] = 1'b1;
        t = urand(STALL_TAG);
        sel = urand(4);
        if (!stall && !draining && sel == 0 && !referenced(t)) pend[t] = 1'b1;   // new producer
        if (!draining && dcount < N_DISPATCH && q.size() < branch_core_pkg::RS_DEPTH
            && urand(4) != 0) begin
            e.inum = dcount;
            e.pc = $random(seed);
            e.pc[1:0] = 2'b00;
            e.inst = $random(seed);
            sel = urand(4);
            if (sel == 0) e.inst.i_view.opcode = branch_isa_pkg::OP_JAL;
            else if (sel == 1) e.inst.i_view.opcode = branch_isa_pkg::OP_JALR;
            else begin
                e.inst.b_view.opcode = branch_isa_pkg::OP_BRANCH;
                sel = urand(6);
                e.inst.b_view.funct3 = 3'((sel < 2) ? sel : sel + 2);   // skips 010 and 011
            end
            e.rd_tag = urand(branch_core_pkg::PREG_COUNT);
            e.s1 = stall ? STALL_TAG : urand(STALL_TAG);
            e.s2 = (urand(4) == 0) ? e.s1 : urand(STALL_TAG);   // equal operands now and then
            e.pred_taken = urand(3) != 0;
            e.pred_target = urand(2) ? target_of(e) : $random(seed);
            dispatch_valid       <= 1'b1;
            dispatch_inum        <= e.inum;
            dispatch_pc          <= e.pc;
            dispatch_inst        <= e.inst;
            dispatch_rd_tag      <= e.rd_tag;
            dispatch_src1_tag    <= e.s1;
            dispatch_src2_tag    <= e.s2;
            dispatch_src1_ready  <= !pend[e.s1];
            dispatch_src2_ready  <= !pend[e.s2];
            dispatch_pred_taken  <= e.pred_taken;
            dispatch_pred_target <= e.pred_target;
            q.push_back(e);
            dcount++;
        end
        // readiness above is sampled first so a same-cycle broadcast is covered
        if ((draining || (!stall && urand(3) == 0)) && pick_pending(t)) begin
            d = $random(seed);
            wb0_valid <= 1'b1;
            wb0_tag   <= t;
            wb0_data  <= d;
            regs[t] = d;
            pend[t] = 1'b0;
            if (urand(4) == 0 && pick_pending(t)) begin
                d = $random(seed);
                wb1_valid <= 1'b1;
                wb1_tag   <= t;
                wb1_data  <= d;
                regs[t] = d;
                pend[t] = 1'b0;
            end
        end
    endtask

    task automatic check_cycle();
        entry_t      e;
        logic        taken;
        logic [31:0] target;
        string       name;
        if (rs_full) full_seen = 1'b1;
        if (rs_full && q.size() < branch_core_pkg::RS_DEPTH) begin
            $display("rs_full is high with only %0d branches outstanding", q.size());
            failures++;
        end
        if (link_valid && !resolve_valid) begin
            $display("link_valid is high without a resolve");
            failures++;
        end
        if (mispredict && !resolve_valid) begin
            $display("mispredict is high without a resolve");
            failures++;
        end
        if (resolve_valid && q.size() == 0) begin
            $display("resolve of inum %0d with no branch outstanding", resolve_inum);
            failures++;
        end else if (resolve_valid) begin
            e = q.pop_front();
            taken = taken_of(e);
            target = target_of(e);
            name = $sformatf("inum %0d", e.inum);
            check_resolve(name, e.inum, taken, taken ? target : e.pc + 32'd4,
                          (taken != e.pred_taken) || (taken && target != e.pred_target));
            if (e.inst[6:0] == branch_isa_pkg::OP_BRANCH && link_valid) begin
                $display("link_valid raised for conditional branch %s", name);
                failures++;
            end else if (e.inst[6:0] != branch_isa_pkg::OP_BRANCH && !link_valid) begin
                $display("link_valid missing for jump %s", name);
                failures++;
            end else if (link_valid) begin
                check_link(name, e.rd_tag, e.pc + 32'd4);
            end
        end
        if (mispredict) q.delete();   // all still unresolved are younger
    endtask

    task automatic run_cycle();
        @(posedge clk);
        drive_stimulus();
        @(negedge clk);
        check_cycle();
        cycle++;
    endtask

    initial begin
        reset                = 1'b1;
        dispatch_valid       = 1'b0;
        dispatch_inum        = '0;
        dispatch_pc          = '0;
        dispatch_inst        = '0;
        dispatch_rd_tag      = '0;
        dispatch_src1_tag    = '0;
        dispatch_src2_tag    = '0;
        dispatch_src1_ready  = 1'b0;
        dispatch_src2_ready  = 1'b0;
        dispatch_pred_taken  = 1'b0;
        dispatch_pred_target = '0;
        wb0_valid            = 1'b0;
        wb0_tag              = '0;
        wb0_data             = '0;
        wb1_valid            = 1'b0;
        wb1_tag              = '0;
        wb1_data             = '0;
        foreach (regs[i]) regs[i] = '0;   // register file clears on reset
        pend = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (rs_full !== 1'b0 || resolve_valid !== 1'b0 || mispredict !== 1'b0
            || link_valid !== 1'b0) begin
            $display("outputs are not idle after reset");
            failures++;
        end
        while (dcount < N_DISPATCH) run_cycle();
        draining = 1'b1;
        while (q.size() != 0) run_cycle();
        repeat (10) run_cycle();   // nothing flushed may show up late
        if (!full_seen) begin
            $display("rs_full never rose during the run");
            failures++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: branch_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               dispatch_valid,
    input  logic [branch_core_pkg::INUM_W-1:0] dispatch_inum,
    input  logic [branch_core_pkg::XLEN-1:0]   dispatch_pc,
    input  branch_isa_pkg::inst_word_u         dispatch_inst,
    input  logic [branch_core_pkg::PTAG_W-1:0] dispatch_rd_tag,
    input  logic [branch_core_pkg::PTAG_W-1:0] dispatch_src1_tag,
    input  logic [branch_core_pkg::PTAG_W-1:0] dispatch_src2_tag,
    input  logic                               dispatch_src1_ready,
    input  logic                               dispatch_src2_ready,
    input  logic                               dispatch_pred_taken,
    input  logic [branch_core_pkg::XLEN-1:0]   dispatch_pred_target,
    input  logic                               wb0_valid,
    input  logic [branch_core_pkg::PTAG_W-1:0] wb0_tag,
    input  logic [branch_core_pkg::XLEN-1:0]   wb0_data,
    input  logic                               wb1_valid,
    input  logic [branch_core_pkg::PTAG_W-1:0] wb1_tag,
    input  logic [branch_core_pkg::XLEN-1:0]   wb1_data,
    output logic                               rs_full,
    output logic                               resolve_valid,
    output logic [branch_core_pkg::INUM_W-1:0] resolve_inum,
    output logic                               resolve_taken,
    output logic                               mispredict,
    output logic [branch_core_pkg::XLEN-1:0]   redirect_pc,
    output logic                               link_valid,
    output logic [branch_core_pkg::PTAG_W-1:0] link_tag,
    output logic [branch_core_pkg::XLEN-1:0]   link_data
);

    // issue stage
    logic                               iss_valid;
    logic [branch_core_pkg::INUM_W-1:0] iss_inum;
    logic [branch_core_pkg::XLEN-1:0]   iss_pc;
    branch_isa_pkg::inst_word_u         iss_inst;
    logic [branch_core_pkg::PTAG_W-1:0] iss_rd_tag;
    logic [branch_core_pkg::PTAG_W-1:0] iss_src1_tag;
    logic [branch_core_pkg::PTAG_W-1:0] iss_src2_tag;
    logic                               iss_pred_taken;
    logic [branch_core_pkg::XLEN-1:0]   iss_pred_target;

    // operand read stage
    logic                               rd_valid;
    logic [branch_core_pkg::INUM_W-1:0] rd_inum;
    logic [branch_core_pkg::XLEN-1:0]   rd_pc;
    branch_isa_pkg::inst_word_u         rd_inst;
    logic [branch_core_pkg::PTAG_W-1:0] rd_rd_tag;
    logic                               rd_pred_taken;
    logic [branch_core_pkg::XLEN-1:0]   rd_pred_target;
    logic [branch_core_pkg::XLEN-1:0]   rd_src1_data;
    logic [branch_core_pkg::XLEN-1:0]   rd_src2_data;

    // registered mispredict kills everything younger
    branch_rs branch_rs_i (
        .flush(mispredict),
        .*
    );

    branch_operand_read branch_operand_read_i (
        .flush(mispredict),
        .*
    );

    branch_resolve branch_resolve_i (.*);

endmodule

`default_nettype wire
